//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --timescale 1ns/1ps
TB_TOP    := tb_branch_predict_unit
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/bht.sv
`default_nettype none

module bht (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  rv_isa_pkg::addr_t    pc_i,
	input  rv_isa_pkg::addr_t    pc_ex_i,
	input  logic                 we_i,
	input  bpu_pkg::mispredict_e mispredict_i,
	output logic                 pred_taken_o
);

	bpu_pkg::ctr_e   ctr_q [bpu_pkg::BTB_ENTRIES];
	bpu_pkg::ctr_e   ctr_cur;
	bpu_pkg::ctr_e   ctr_next;
	bpu_pkg::index_t fetch_idx;
	bpu_pkg::index_t ex_idx;

	assign fetch_idx = bpu_pkg::get_index(pc_i);
	assign ex_idx    = bpu_pkg::get_index(pc_ex_i);
	assign ctr_cur   = ctr_q[ex_idx];

	// step the execute entry, a correct guess strengthens a weak state
	always_comb begin
		ctr_next = ctr_cur;
		case (ctr_cur)
			bpu_pkg::CTR_SNT: begin
				if (mispredict_i == bpu_pkg::MP_MISSED) ctr_next = bpu_pkg::CTR_WNT;
			end
			bpu_pkg::CTR_WNT: begin
				if (mispredict_i == bpu_pkg::MP_MISSED) ctr_next = bpu_pkg::CTR_WT;
				else ctr_next = bpu_pkg::CTR_SNT;
			end
			bpu_pkg::CTR_WT: begin
				if (mispredict_i == bpu_pkg::MP_FALSE_TAKEN) ctr_next = bpu_pkg::CTR_WNT;
				else ctr_next = bpu_pkg::CTR_ST;
			end
			bpu_pkg::CTR_ST: begin
				if (mispredict_i == bpu_pkg::MP_FALSE_TAKEN) ctr_next = bpu_pkg::CTR_WT;
			end
			default: ctr_next = bpu_pkg::CTR_ST;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			for (int i = 0; i < bpu_pkg::BTB_ENTRIES; i++) begin
				ctr_q[i] <= bpu_pkg::CTR_ST;
			end
		end else if (we_i) begin
			ctr_q[ex_idx] <= ctr_next;
		end
	end

	// both taken states predict taken
	assign pred_taken_o = (ctr_q[fetch_idx] == bpu_pkg::CTR_WT) ||
		(ctr_q[fetch_idx] == bpu_pkg::CTR_ST);

endmodule

`default_nettype wire

//--- design/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

	// the BTB and the counter table share one geometry
	localparam int unsigned BTB_ENTRIES = 32;
	localparam int unsigned INDEX_W     = $clog2(BTB_ENTRIES);

	// word aligned PCs, so the index starts above the byte offset
	localparam int unsigned INDEX_LSB = 2;
	localparam int unsigned TAG_LSB   = INDEX_LSB + INDEX_W;
	localparam int unsigned TAG_W     = rv_isa_pkg::XLEN - TAG_LSB;

	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [TAG_W-1:0]   tag_t;

	// 2-bit saturating direction counter, taken when the msb is set
	typedef enum logic [1:0] {
		CTR_SNT = 2'b00,
		CTR_WNT = 2'b01,
		CTR_WT  = 2'b10,
		CTR_ST  = 2'b11
	} ctr_e;

	// outcome of a prediction, resolved at execute
	typedef enum logic [1:0] {
		MP_NONE        = 2'b00,
		MP_FALSE_TAKEN = 2'b01,
		MP_MISSED      = 2'b10
	} mispredict_e;

	function automatic index_t get_index(input rv_isa_pkg::addr_t pc);
		return pc[INDEX_LSB +: INDEX_W];
	endfunction

	function automatic tag_t get_tag(input rv_isa_pkg::addr_t pc);
		return pc[TAG_LSB +: TAG_W];
	endfunction

endpackage

`default_nettype wire

//--- design/branch_predict_unit.sv
`default_nettype none

module branch_predict_unit (
	input  logic                 clk_i,
	input  logic                 rst_ni,
	input  rv_isa_pkg::addr_t    pc_i,
	input  rv_isa_pkg::addr_t    pc_ex_i,
	input  rv_isa_pkg::inst_t    inst_ex_i,
	input  rv_isa_pkg::xlen_t    rs1_i,
	input  rv_isa_pkg::xlen_t    rs2_i,
	input  rv_isa_pkg::addr_t    target_ex_i,
	input  logic                 hit_ex_i,
	input  logic                 advance_i,
	output logic                 hit_o,
	output rv_isa_pkg::addr_t    pred_target_o,
	output bpu_pkg::mispredict_e mispredict_o,
	output logic                 flush_o,
	output rv_isa_pkg::addr_t    next_pc_o
);

	logic              tag_hit;
	logic              pred_taken;
	rv_isa_pkg::addr_t btb_ex_target;
	logic              taken;
	logic              is_cf;
	logic              tbl_we;
	logic              btb_we;

	// only control-flow instructions train the tables, and only on advance
	assign tbl_we = advance_i && is_cf;
	// a not-taken branch keeps whatever entry is there
	assign btb_we = tbl_we && taken;

	// predict taken only with a matching entry and a taken counter
	assign hit_o = tag_hit && pred_taken;

	branch_resolver u_resolver (
		.inst_ex_i       (inst_ex_i),
		.rs1_i           (rs1_i),
		.rs2_i           (rs2_i),
		.target_ex_i     (target_ex_i),
		.hit_ex_i        (hit_ex_i),
		.btb_ex_target_i (btb_ex_target),
		.taken_o         (taken),
		.is_cf_o         (is_cf),
		.mispredict_o    (mispredict_o)
	);

	btb u_btb (
		.clk_i         (clk_i),
		.rst_ni        (rst_ni),
		.pc_i          (pc_i),
		.pc_ex_i       (pc_ex_i),
		.we_i          (btb_we),
		.target_i      (target_ex_i),
		.tag_hit_o     (tag_hit),
		.pred_target_o (pred_target_o),
		.ex_target_o   (btb_ex_target)
	);

	bht u_bht (
		.clk_i        (clk_i),
		.rst_ni       (rst_ni),
		.pc_i         (pc_i),
		.pc_ex_i      (pc_ex_i),
		.we_i         (tbl_we),
		.mispredict_i (mispredict_o),
		.pred_taken_o (pred_taken)
	);

	next_pc_sel u_next_pc (
		.pc_i          (pc_i),
		.pc_ex_i       (pc_ex_i),
		.target_ex_i   (target_ex_i),
		.mispredict_i  (mispredict_o),
		.hit_i         (hit_o),
		.pred_target_i (pred_target_o),
		.next_pc_o     (next_pc_o),
		.flush_o       (flush_o)
	);

endmodule

`default_nettype wire

//--- design/branch_resolver.sv
`default_nettype none

module branch_resolver (
	input  rv_isa_pkg::inst_t     inst_ex_i,
	input  rv_isa_pkg::xlen_t     rs1_i,
	input  rv_isa_pkg::xlen_t     rs2_i,
	input  rv_isa_pkg::addr_t     target_ex_i,
	input  logic                  hit_ex_i,
	input  rv_isa_pkg::addr_t     btb_ex_target_i,
	output logic                  taken_o,
	output logic                  is_cf_o,
	output bpu_pkg::mispredict_e  mispredict_o
);

	rv_isa_pkg::opcode_t opcode;
	rv_isa_pkg::funct3_t funct3;
	logic                is_branch;
	logic                is_jump;
	logic                op_eq;
	logic                op_lt_s;
	logic                op_lt_u;
	logic                cond;

	assign opcode = inst_ex_i[rv_isa_pkg::OPCODE_LSB +: 7];
	assign funct3 = inst_ex_i[rv_isa_pkg::FUNCT3_LSB +: 3];

	assign is_branch = (opcode == rv_isa_pkg::OP_BRANCH);
	assign is_jump   = (opcode == rv_isa_pkg::OP_JAL) || (opcode == rv_isa_pkg::OP_JALR);

	// one comparator set, funct3 picks which result counts
	assign op_eq   = (rs1_i == rs2_i);
	assign op_lt_s = ($signed(rs1_i) < $signed(rs2_i));
	assign op_lt_u = (rs1_i < rs2_i);

	always_comb begin
		case (funct3)
			rv_isa_pkg::F3_BEQ:  cond = op_eq;
			rv_isa_pkg::F3_BNE:  cond = !op_eq;
			rv_isa_pkg::F3_BLT:  cond = op_lt_s;
			rv_isa_pkg::F3_BGE:  cond = !op_lt_s;
			rv_isa_pkg::F3_BLTU: cond = op_lt_u;
			rv_isa_pkg::F3_BGEU: cond = !op_lt_u;
			// reserved encodings never branch
			default:             cond = 1'b0;
		endcase
	end

	assign taken_o = is_jump || (is_branch && cond);
	assign is_cf_o = is_branch || is_jump;

	// hit_ex_i means fetch already steered to the stored target
	always_comb begin
		if (!taken_o && hit_ex_i) begin
			mispredict_o = bpu_pkg::MP_FALSE_TAKEN;
		end else if (taken_o && !hit_ex_i) begin
			mispredict_o = bpu_pkg::MP_MISSED;
		end else if (taken_o && (target_ex_i != btb_ex_target_i)) begin
			// right direction but stale target
			mispredict_o = bpu_pkg::MP_MISSED;
		end else begin
			mispredict_o = bpu_pkg::MP_NONE;
		end
	end

endmodule

`default_nettype wire

//--- design/btb.sv
`default_nettype none

module btb (
	input  logic              clk_i,
	input  logic              rst_ni,
	input  rv_isa_pkg::addr_t pc_i,
	input  rv_isa_pkg::addr_t pc_ex_i,
	input  logic              we_i,
	input  rv_isa_pkg::addr_t target_i,
	output logic              tag_hit_o,
	output rv_isa_pkg::addr_t pred_target_o,
	output rv_isa_pkg::addr_t ex_target_o
);

	// direct mapped, one entry per index
	bpu_pkg::tag_t     tag_q    [bpu_pkg::BTB_ENTRIES];
	logic              valid_q  [bpu_pkg::BTB_ENTRIES];
	rv_isa_pkg::addr_t target_q [bpu_pkg::BTB_ENTRIES];

	bpu_pkg::index_t   fetch_idx;
	bpu_pkg::index_t   ex_idx;
	bpu_pkg::tag_t     fetch_tag;

	assign fetch_idx = bpu_pkg::get_index(pc_i);
	assign fetch_tag = bpu_pkg::get_tag(pc_i);
	assign ex_idx    = bpu_pkg::get_index(pc_ex_i);

	always_ff @(posedge clk_i) begin
		if (!rst_ni) begin
			for (int i = 0; i < bpu_pkg::BTB_ENTRIES; i++) begin
				tag_q[i]    <= '0;
				valid_q[i]  <= 1'b0;
				target_q[i] <= '0;
			end
		end else if (we_i) begin
			tag_q[ex_idx]    <= bpu_pkg::get_tag(pc_ex_i);
			valid_q[ex_idx]  <= 1'b1;
			target_q[ex_idx] <= target_i;
		end
	end

	// fetch side lookup
	assign tag_hit_o     = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
	assign pred_target_o = target_q[fetch_idx];

	// execute side, used to catch a stale target after a hit
	assign ex_target_o = target_q[ex_idx];

endmodule

`default_nettype wire

//--- design/next_pc_sel.sv
`default_nettype none

module next_pc_sel (
	input  rv_isa_pkg::addr_t    pc_i,
	input  rv_isa_pkg::addr_t    pc_ex_i,
	input  rv_isa_pkg::addr_t    target_ex_i,
	input  bpu_pkg::mispredict_e mispredict_i,
	input  logic                 hit_i,
	input  rv_isa_pkg::addr_t    pred_target_i,
	output rv_isa_pkg::addr_t    next_pc_o,
	output logic                 flush_o
);

	rv_isa_pkg::addr_t fetch_seq;
	rv_isa_pkg::addr_t ex_seq;

	assign fetch_seq = pc_i + rv_isa_pkg::INST_BYTES;
	assign ex_seq    = pc_ex_i + rv_isa_pkg::INST_BYTES;

	// execute redirects override anything fetch predicted
	always_comb begin
		if (mispredict_i == bpu_pkg::MP_FALSE_TAKEN) begin
			next_pc_o = ex_seq;
		end else if (mispredict_i == bpu_pkg::MP_MISSED) begin
			next_pc_o = target_ex_i;
		end else if (hit_i) begin
			next_pc_o = pred_target_i;
		end else begin
			next_pc_o = fetch_seq;
		end
	end

	// any wrong guess kills the younger instructions
	assign flush_o = (mispredict_i != bpu_pkg::MP_NONE);

endmodule

`default_nettype wire

//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

	localparam int unsigned XLEN = 32;

	// byte address, instruction word and register operand
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [31:0]     inst_t;
	typedef logic [XLEN-1:0] xlen_t;

	// major and minor opcode fields
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;

	// field positions inside the instruction word
	localparam int unsigned OPCODE_LSB = 0;
	localparam int unsigned FUNCT3_LSB = 12;

	// size of one instruction in bytes, the sequential PC step
	localparam addr_t INST_BYTES = 32'd4;

	// control-flow major opcodes
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;

	// branch conditions
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

endpackage

`default_nettype wire

//--- sim/tb_vectors.svh
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

	// each row holds the name and the inputs pc, pc_ex, inst_ex, rs1, rs2, target_ex, hit_ex
	// and advance, then the expected hit, pred_target, mispredict, flush and next_pc
	localparam int unsigned NUM_VECTORS = 20;

	localparam vector_t VECTORS [NUM_VECTORS] = '{
		// tables empty after reset
		'{"reset_nop", 32'h00000000, 32'h00000ffc, I_NOP, 32'h00000000, 32'h00000000,
			32'h00000000, 1'b0, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_NONE, 1'b0, 32'h00000004},
		'{"beq_miss", 32'h00001010, 32'h00001040, I_BEQ, 32'h00000005, 32'h00000005,
			32'h00001200, 1'b0, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_MISSED, 1'b1, 32'h00001200},
		'{"beq_fetch_hit", 32'h00001040, 32'h00001014, I_NOP, 32'h00000000, 32'h00000000,
			32'h00000000, 1'b0, 1'b1, 1'b1, 32'h00001200, bpu_pkg::MP_NONE, 1'b0, 32'h00001200},
		// rs1 is -16 signed and rs2 is 16
		'{"bne_taken", 32'h00002000, 32'h00002104, I_BNE, 32'hfffffff0, 32'h00000010,
			32'h00002300, 1'b0, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_MISSED, 1'b1, 32'h00002300},
		'{"blt_taken", 32'h00002000, 32'h00002108, I_BLT, 32'hfffffff0, 32'h00000010,
			32'h00002310, 1'b0, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_MISSED, 1'b1, 32'h00002310},
		'{"bge_not_taken", 32'h00002000, 32'h0000210c, I_BGE, 32'hfffffff0, 32'h00000010,
			32'h00002330, 1'b0, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_NONE, 1'b0, 32'h00002004},
		'{"bltu_not_taken", 32'h00002000, 32'h00002110, I_BLTU, 32'hfffffff0, 32'h00000010,
			32'h00002340, 1'b0, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_NONE, 1'b0, 32'h00002004},
		'{"bgeu_taken", 32'h0000210c, 32'h00002114, I_BGEU, 32'hfffffff0, 32'h00000010,
			32'h00002350, 1'b0, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_MISSED, 1'b1, 32'h00002350},
		// counter at index 16 walks ST, WT, WNT and back up
		'{"false_taken_1", 32'h00002000, 32'h00001040, I_BEQ, 32'h00000001, 32'h00000002,
			32'h00001200, 1'b1, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_FALSE_TAKEN, 1'b1,
			32'h00001044},
		'{"false_taken_2", 32'h00001040, 32'h00001040, I_BEQ, 32'h00000001, 32'h00000002,
			32'h00001200, 1'b1, 1'b1, 1'b1, 32'h00001200, bpu_pkg::MP_FALSE_TAKEN, 1'b1,
			32'h00001044},
		'{"weak_nt_fetch", 32'h00001040, 32'h00002040, I_NOP, 32'h00000000, 32'h00000000,
			32'h00000000, 1'b0, 1'b1, 1'b0, 32'h00001200, bpu_pkg::MP_NONE, 1'b0, 32'h00001044},
		'{"missed_1", 32'h00001040, 32'h00001040, I_BEQ, 32'h00000007, 32'h00000007,
			32'h00001200, 1'b0, 1'b1, 1'b0, 32'h00001200, bpu_pkg::MP_MISSED, 1'b1, 32'h00001200},
		'{"missed_2", 32'h00001040, 32'h00001040, I_BEQ, 32'h00000007, 32'h00000007,
			32'h00001200, 1'b0, 1'b1, 1'b1, 32'h00001200, bpu_pkg::MP_MISSED, 1'b1, 32'h00001200},
		'{"taken_fetch", 32'h00001040, 32'h00002204, I_NOP, 32'h00000000, 32'h00000000,
			32'h00000000, 1'b0, 1'b1, 1'b1, 32'h00001200, bpu_pkg::MP_NONE, 1'b0, 32'h00001200},
		// stale target at index 1
		'{"jalr_new_target", 32'h00002000, 32'h00002104, I_JALR, 32'h00000000, 32'h00000000,
			32'h00002400, 1'b1, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_MISSED, 1'b1, 32'h00002400},
		'{"jalr_fetch", 32'h00002104, 32'h00002208, I_NOP, 32'h00000000, 32'h00000000,
			32'h00000000, 1'b0, 1'b1, 1'b1, 32'h00002400, bpu_pkg::MP_NONE, 1'b0, 32'h00002400},
		'{"jal_correct", 32'h00002000, 32'h00002108, I_JAL, 32'h00000000, 32'h00000000,
			32'h00002310, 1'b1, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_NONE, 1'b0, 32'h00002004},
		// back-pressure holds the tables
		'{"stall_missed", 32'h00002000, 32'h00003018, I_BEQ, 32'h00000003, 32'h00000003,
			32'h00003100, 1'b0, 1'b0, 1'b0, 32'h00000000, bpu_pkg::MP_MISSED, 1'b1, 32'h00003100},
		'{"stall_fetch", 32'h00003018, 32'h0000220c, I_NOP, 32'h00000000, 32'h00000000,
			32'h00000000, 1'b0, 1'b1, 1'b0, 32'h00000000, bpu_pkg::MP_NONE, 1'b0, 32'h0000301c},
		'{"alias_tag", 32'h00005040, 32'h00002210, I_NOP, 32'h00000000, 32'h00000000,
			32'h00000000, 1'b0, 1'b1, 1'b0, 32'h00001200, bpu_pkg::MP_NONE, 1'b0, 32'h00005044}
	};

`endif

//--- sim/tb_branch_predict_unit.sv
`default_nettype none

module tb_branch_predict_unit;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int unsigned CLK_PERIOD   = 100;
	localparam int unsigned RESET_CYCLES = 3;

	// real encodings, the resolver only looks at opcode and funct3
	localparam rv_isa_pkg::inst_t I_NOP  = 32'h00000013;
	localparam rv_isa_pkg::inst_t I_BEQ  = 32'h00208063;
	localparam rv_isa_pkg::inst_t I_BNE  = 32'h00209063;
	localparam rv_isa_pkg::inst_t I_BLT  = 32'h0020c063;
	localparam rv_isa_pkg::inst_t I_BGE  = 32'h0020d063;
	localparam rv_isa_pkg::inst_t I_BLTU = 32'h0020e063;
	localparam rv_isa_pkg::inst_t I_BGEU = 32'h0020f063;
	localparam rv_isa_pkg::inst_t I_JAL  = 32'h000000ef;
	localparam rv_isa_pkg::inst_t I_JALR = 32'h00008067;

	typedef struct packed {
		logic [8*16-1:0]      name;
		rv_isa_pkg::addr_t    pc;
		rv_isa_pkg::addr_t    pc_ex;
		rv_isa_pkg::inst_t    inst_ex;
		rv_isa_pkg::xlen_t    rs1;
		rv_isa_pkg::xlen_t    rs2;
		rv_isa_pkg::addr_t    target_ex;
		logic                 hit_ex;
		logic                 advance;
		logic                 exp_hit;
		rv_isa_pkg::addr_t    exp_pred_target;
		bpu_pkg::mispredict_e exp_mispredict;
		logic                 exp_flush;
		rv_isa_pkg::addr_t    exp_next_pc;
	} vector_t;

`include "tb_vectors.svh"

	localparam int unsigned WATCHDOG_TIME = NUM_VECTORS * CLK_PERIOD + 10 * CLK_PERIOD;

	logic                 clk;
	logic                 rst_n;
	rv_isa_pkg::addr_t    pc;
	rv_isa_pkg::addr_t    pc_ex;
	rv_isa_pkg::inst_t    inst_ex;
	rv_isa_pkg::xlen_t    rs1;
	rv_isa_pkg::xlen_t    rs2;
	rv_isa_pkg::addr_t    target_ex;
	logic                 hit_ex;
	logic                 advance;
	logic                 hit;
	rv_isa_pkg::addr_t    pred_target;
	bpu_pkg::mispredict_e mispredict;
	logic                 flush;
	rv_isa_pkg::addr_t    next_pc;

	branch_predict_unit i_branch_predict_unit (
		.clk_i         (clk),
		.rst_ni        (rst_n),
		.pc_i          (pc),
		.pc_ex_i       (pc_ex),
		.inst_ex_i     (inst_ex),
		.rs1_i         (rs1),
		.rs2_i         (rs2),
		.target_ex_i   (target_ex),
		.hit_ex_i      (hit_ex),
		.advance_i     (advance),
		.hit_o         (hit),
		.pred_target_o (pred_target),
		.mispredict_o  (mispredict),
		.flush_o       (flush),
		.next_pc_o     (next_pc)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk = ~clk;
		end
	end

	task automatic check_addr(input string test_name, input string signal,
		input rv_isa_pkg::addr_t expected, input rv_isa_pkg::addr_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: %s expected %h, actual %h", test_name, signal, expected, actual);
			$display("Something failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_code(input string test_name, input string signal,
		input bpu_pkg::mispredict_e expected, input bpu_pkg::mispredict_e actual);
		if (actual !== expected) begin
			$display("ERROR %s: %s expected %s, actual %s (%0d)", test_name, signal,
				expected.name(), actual.name(), actual);
			$display("Something failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic check_bit(input string test_name, input string signal,
		input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: %s expected %b, actual %b", test_name, signal, expected, actual);
			$display("Something failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	task automatic drive_row(input vector_t v);
		pc        = v.pc;
		pc_ex     = v.pc_ex;
		inst_ex   = v.inst_ex;
		rs1       = v.rs1;
		rs2       = v.rs2;
		target_ex = v.target_ex;
		hit_ex    = v.hit_ex;
		advance   = v.advance;
	endtask

	task automatic check_row(input vector_t v);
		string test_name;
		test_name = string'(v.name);
		check_bit(test_name, "hit_o", v.exp_hit, hit);
		check_addr(test_name, "pred_target_o", v.exp_pred_target, pred_target);
		check_code(test_name, "mispredict_o", v.exp_mispredict, mispredict);
		check_bit(test_name, "flush_o", v.exp_flush, flush);
		check_addr(test_name, "next_pc_o", v.exp_next_pc, next_pc);
	endtask

	initial begin
		rst_n     = 1'b0;
		pc        = '0;
		pc_ex     = '0;
		inst_ex   = I_NOP;
		rs1       = '0;
		rs2       = '0;
		target_ex = '0;
		hit_ex    = 1'b0;
		advance   = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < NUM_VECTORS; i++) begin
			@(negedge clk);
			drive_row(VECTORS[i]);
			// sample just ahead of the edge that commits the table update
			#(CLK_PERIOD / 2 - 1);
			check_row(VECTORS[i]);
		end
		$display("Everything OK");
		$finish;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("timeout: the vector loop did not finish within %0d ns", WATCHDOG_TIME);
		$display("Something failed");
		$fatal(1, "simulation timed out");
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+sim
design/rv_isa_pkg.sv
design/bpu_pkg.sv
design/branch_resolver.sv
design/btb.sv
design/bht.sv
design/next_pc_sel.sv
design/branch_predict_unit.sv
sim/tb_branch_predict_unit.sv
